/* rtl/phy_rx_consts.svh */
// receive PHY constants
`ifndef PHY_RX_CONSTS_SVH
`define PHY_RX_CONSTS_SVH

// lane word: 32-bit payload plus 2-bit sync header
`define PHY_DATA_W 32
`define PHY_HDR_W 2

// descrambler polynomial x^58 + x^39 + 1
`define SCR_W 58
`define SCR_TAP 39

// test pattern polynomial x^31 + x^28 + 1
`define PRBS_W 31
`define PRBS_TAP 28

// block lock window and error threshold
`define SYNC_WINDOW 64
`define SYNC_BAD_MAX 16

// bitslip pulse shape, in clock cycles
`define BITSLIP_HIGH 1
`define BITSLIP_LOW 7

// bit error count, wide enough for 34 errors
`define ERR_CNT_W 7

`endif

/* rtl/phy_rx_block_pkg.sv */
// line-side block word types
`include "phy_rx_consts.svh"

package phy_rx_block_pkg;

    // only 01 and 10 are legal sync headers
    typedef enum logic [`PHY_HDR_W-1:0] {
        SYNC_HDR_BAD_LO = 2'b00,
        SYNC_HDR_DATA   = 2'b01,
        SYNC_HDR_CTRL   = 2'b10,
        SYNC_HDR_BAD_HI = 2'b11
    } sync_hdr_t;

    // header sits in the low bits, first on the line
    typedef struct packed {
        logic [`PHY_DATA_W-1:0] payload;
        sync_hdr_t              hdr;
    } rx_fields_t;

    // flat view feeds the test pattern checker
    typedef union packed {
        rx_fields_t                          fields;
        logic [`PHY_DATA_W+`PHY_HDR_W-1:0]   flat;
    } rx_word_u;

endpackage

/* rtl/phy_rx_status_pkg.sv */
// lock and error status types
`include "phy_rx_consts.svh"

package phy_rx_status_pkg;

    // block lock FSM states
    typedef enum logic [1:0] {
        SYNC_HUNT   = 2'd0,
        SYNC_LOCKED = 2'd1,
        SYNC_SLIP   = 2'd2
    } sync_state_t;

    // per-word bit error count
    typedef logic [`ERR_CNT_W-1:0] err_cnt_t;

endpackage

/* rtl/serdes_rx_if.sv */
// SERDES receive word bundle
`timescale 1ns/1ns
`include "phy_rx_consts.svh"

interface serdes_rx_if;

    // payload and its gearbox valid
    logic [`PHY_DATA_W-1:0] data;
    logic                   data_valid;

    // sync header, valid on every other word with a 32-bit lane
    logic [`PHY_HDR_W-1:0]  hdr;
    logic                   hdr_valid;

    // driven from the top level ports
    modport source (output data, data_valid, hdr, hdr_valid);

    // read by the datapath and lock logic
    modport sink (input data, data_valid, hdr, hdr_valid);

endinterface

/* rtl/rx_descrambler.sv */
// self-synchronizing 64b/66b descrambler
`timescale 1ns/1ns
`include "phy_rx_consts.svh"

module rx_descrambler (
    input  logic                   clk,
    input  logic                   rst,
    serdes_rx_if.sink              rx,
    output logic [`PHY_DATA_W-1:0] encoded_rx_data,
    output logic                   encoded_rx_data_valid,
    output logic [`PHY_HDR_W-1:0]  encoded_rx_hdr,
    output logic                   encoded_rx_hdr_valid
);
    import phy_rx_block_pkg::*;

    // received bits behind the current word, plus the word itself
    localparam int HIST_W = `SCR_W + `PHY_DATA_W;

    rx_word_u               in_word;
    logic [`SCR_W-1:0]      scr_state;
    logic [HIST_W-1:0]      hist;
    logic [`PHY_DATA_W-1:0] plain;

    // bit 0 is first on the line
    // out = in ^ in(-39) ^ in(-58)
    always_comb begin
        in_word.fields.payload = rx.data;
        in_word.fields.hdr = sync_hdr_t'(rx.hdr);
        hist = {in_word.fields.payload, scr_state};
        for (int i = 0; i < `PHY_DATA_W; i++) begin
            plain[i] = hist[`SCR_W+i] ^ hist[`SCR_W+i-`SCR_TAP] ^ hist[i];
        end
    end

    // state holds the last 58 received bits
    // stalls on gearbox gaps
    always_ff @(posedge clk) begin
        if (rst) begin
            scr_state <= '1;
        end else if (rx.data_valid) begin
            scr_state <= hist[HIST_W-1 -: `SCR_W];
        end
    end

    // one cycle output register, valids mirror the input
    always_ff @(posedge clk) begin
        if (rst) begin
            encoded_rx_data <= '0;
            encoded_rx_data_valid <= 1'b0;
            encoded_rx_hdr <= '0;
            encoded_rx_hdr_valid <= 1'b0;
        end else begin
            encoded_rx_data <= plain;
            encoded_rx_data_valid <= rx.data_valid;
            encoded_rx_hdr <= in_word.fields.hdr;
            encoded_rx_hdr_valid <= rx.hdr_valid;
        end
    end

    // header slots only ever land on gearbox-valid words
    a_hdr_needs_data: assert property (
        @(posedge clk) disable iff (rst) rx.hdr_valid |-> rx.data_valid
    );

endmodule

/* rtl/prbs31_checker.sv */
// PRBS31 test pattern checker
`timescale 1ns/1ns
`include "phy_rx_consts.svh"

module prbs31_checker (
    input  logic                        clk,
    input  logic                        rst,
    serdes_rx_if.sink                   rx,
    input  logic                        cfg_rx_prbs31_enable,
    output phy_rx_status_pkg::err_cnt_t rx_error_count
);
    import phy_rx_block_pkg::*;
    import phy_rx_status_pkg::*;

    localparam int WORD_W = `PHY_DATA_W + `PHY_HDR_W;
    localparam int HIST_W = `PRBS_W + WORD_W;
    // each half sees 17 bits at most
    localparam int HALF_W = `ERR_CNT_W - 1;

    rx_word_u          in_word;
    logic [WORD_W-1:0] line_bits;
    logic [HIST_W-1:0] hist;
    logic [WORD_W-1:0] err_bits;
    logic [WORD_W-1:0] err_reg;
    logic [`PRBS_W-1:0] prbs_state;
    logic [HALF_W-1:0] odd_sum;
    logic [HALF_W-1:0] even_sum;
    logic [HALF_W-1:0] odd_reg;
    logic [HALF_W-1:0] even_reg;

    // pattern arrives inverted on the line
    // header bits come first on the line
    always_comb begin
        in_word.fields.payload = rx.data;
        in_word.fields.hdr = sync_hdr_t'(rx.hdr);
        line_bits = ~in_word.flat;
        hist = {line_bits, prbs_state};
        // a clean stream gives zero here
        for (int i = 0; i < WORD_W; i++) begin
            err_bits[i] = hist[`PRBS_W+i] ^ hist[`PRBS_W+i-`PRBS_TAP] ^ hist[i];
        end
    end

    // split popcount over odd and even bit positions
    always_comb begin
        odd_sum = '0;
        even_sum = '0;
        for (int i = 0; i < WORD_W; i++) begin
            if (i % 2 == 1) begin
                odd_sum = odd_sum + HALF_W'(err_reg[i]);
            end else begin
                even_sum = even_sum + HALF_W'(err_reg[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prbs_state <= '1;
            err_reg <= '0;
            odd_reg <= '0;
            even_reg <= '0;
            rx_error_count <= '0;
        end else begin
            // first stage holds mismatch bits and clears them when idle or disabled
            if (cfg_rx_prbs31_enable && rx.data_valid) begin
                prbs_state <= hist[HIST_W-1 -: `PRBS_W];
                err_reg <= err_bits;
            end else begin
                err_reg <= '0;
            end
            // second stage takes partial counts
            odd_reg <= odd_sum;
            even_reg <= even_sum;
            // third stage sums them
            rx_error_count <= err_cnt_t'(odd_reg) + err_cnt_t'(even_reg);
        end
    end

    // count never exceeds one word of errors
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) rx_error_count <= err_cnt_t'(WORD_W)
    );

endmodule

/* rtl/block_sync_ctrl.sv */
// sync header block lock FSM
`timescale 1ns/1ns
`include "phy_rx_consts.svh"

module block_sync_ctrl (
    input  logic      clk,
    input  logic      rst,
    serdes_rx_if.sink rx,
    input  logic      cfg_rx_prbs31_enable,
    output logic      serdes_rx_bitslip,
    output logic      rx_block_lock
);
    import phy_rx_block_pkg::*;
    import phy_rx_status_pkg::*;

    localparam int WIN_CNT_W = $clog2(`SYNC_WINDOW);
    localparam int BAD_CNT_W = $clog2(`SYNC_BAD_MAX + 1);
    // pulse high and then headers ignored
    localparam int SLIP_LEN = `BITSLIP_HIGH + `BITSLIP_LOW;
    localparam int SLIP_CNT_W = $clog2(SLIP_LEN + 1);

    sync_state_t           state;
    logic [WIN_CNT_W-1:0]  hdr_cnt;
    logic [BAD_CNT_W-1:0]  bad_cnt;
    logic [SLIP_CNT_W-1:0] slip_cnt;
    logic                  hdr_seen;
    logic                  hdr_ok;
    logic                  win_last;
    logic                  slip_raw;

    // a header counts only on a gearbox-valid word
    assign hdr_seen = rx.data_valid && rx.hdr_valid;
    assign hdr_ok = (rx.hdr == SYNC_HDR_DATA) || (rx.hdr == SYNC_HDR_CTRL);
    assign win_last = hdr_cnt == WIN_CNT_W'(`SYNC_WINDOW - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SYNC_HUNT;
            hdr_cnt <= '0;
            bad_cnt <= '0;
            slip_cnt <= '0;
        end else begin
            case (state)
                SYNC_HUNT: begin
                    if (hdr_seen) begin
                        if (!hdr_ok) begin
                            // wrong alignment so slip at once
                            state <= SYNC_SLIP;
                            slip_cnt <= '0;
                            hdr_cnt <= '0;
                        end else if (win_last) begin
                            // full window of good headers
                            state <= SYNC_LOCKED;
                            hdr_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            hdr_cnt <= hdr_cnt + 1'b1;
                        end
                    end
                end
                SYNC_LOCKED: begin
                    if (hdr_seen) begin
                        if (!hdr_ok && bad_cnt == BAD_CNT_W'(`SYNC_BAD_MAX - 1)) begin
                            // too many bad headers in this window
                            state <= SYNC_SLIP;
                            slip_cnt <= '0;
                            hdr_cnt <= '0;
                            bad_cnt <= '0;
                        end else if (win_last) begin
                            // window closed so start a fresh one
                            hdr_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            hdr_cnt <= hdr_cnt + 1'b1;
                            if (!hdr_ok) begin
                                bad_cnt <= bad_cnt + 1'b1;
                            end
                        end
                    end
                end
                SYNC_SLIP: begin
                    // timer runs on every clock even across gaps
                    if (slip_cnt == SLIP_CNT_W'(SLIP_LEN - 1)) begin
                        state <= SYNC_HUNT;
                        slip_cnt <= '0;
                    end else begin
                        slip_cnt <= slip_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= SYNC_HUNT;
                end
            endcase
        end
    end

    // pulse in the first cycles of the slip
    assign slip_raw = (state == SYNC_SLIP) && (slip_cnt < SLIP_CNT_W'(`BITSLIP_HIGH));

    // no slips while running the test pattern
    assign serdes_rx_bitslip = slip_raw && !cfg_rx_prbs31_enable;
    assign rx_block_lock = state == SYNC_LOCKED;

    // a slip starts only from an invalid header and never while locked
    a_no_slip_locked: assert property (
        @(posedge clk) disable iff (rst)
        $rose(serdes_rx_bitslip) |-> !rx_block_lock && $past(hdr_seen && !hdr_ok)
    );

    a_slip_single: assert property (
        @(posedge clk) disable iff (rst) serdes_rx_bitslip |=> !serdes_rx_bitslip
    );

endmodule

/* rtl/phy_rx_top.sv */
// 10GBASE-R receive interface
`timescale 1ns/1ns
`include "phy_rx_consts.svh"

module phy_rx_top (
    input  logic                        clk,
    input  logic                        rst,

    // SERDES side
    input  logic [`PHY_DATA_W-1:0]      serdes_rx_data,
    input  logic                        serdes_rx_data_valid,
    input  logic [`PHY_HDR_W-1:0]       serdes_rx_hdr,
    input  logic                        serdes_rx_hdr_valid,
    output logic                        serdes_rx_bitslip,

    // test pattern mode
    input  logic                        cfg_rx_prbs31_enable,

    // encoded 64b/66b side
    output logic [`PHY_DATA_W-1:0]      encoded_rx_data,
    output logic                        encoded_rx_data_valid,
    output logic [`PHY_HDR_W-1:0]       encoded_rx_hdr,
    output logic                        encoded_rx_hdr_valid,

    // status
    output logic                        rx_block_lock,
    output phy_rx_status_pkg::err_cnt_t rx_error_count
);

    serdes_rx_if rx_if ();

    // source side of the bundle, straight from the pins
    assign rx_if.data = serdes_rx_data;
    assign rx_if.data_valid = serdes_rx_data_valid;
    assign rx_if.hdr = serdes_rx_hdr;
    assign rx_if.hdr_valid = serdes_rx_hdr_valid;

    // payload path, 1 cycle
    rx_descrambler u_descrambler (
        .clk                   (clk),
        .rst                   (rst),
        .rx                    (rx_if.sink),
        .encoded_rx_data       (encoded_rx_data),
        .encoded_rx_data_valid (encoded_rx_data_valid),
        .encoded_rx_hdr        (encoded_rx_hdr),
        .encoded_rx_hdr_valid  (encoded_rx_hdr_valid)
    );

    // test pattern errors, 3 cycles
    prbs31_checker u_prbs_chk (
        .clk                  (clk),
        .rst                  (rst),
        .rx                   (rx_if.sink),
        .cfg_rx_prbs31_enable (cfg_rx_prbs31_enable),
        .rx_error_count       (rx_error_count)
    );

    // header alignment and bitslip
    block_sync_ctrl u_sync_ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .rx                   (rx_if.sink),
        .cfg_rx_prbs31_enable (cfg_rx_prbs31_enable),
        .serdes_rx_bitslip    (serdes_rx_bitslip),
        .rx_block_lock        (rx_block_lock)
    );

endmodule

/* dv/tb_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset over four rising edges, released off the edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
    end
endmodule

/* dv/tb_phy_rx.sv */
// receive PHY testbench
`timescale 1ns/1ns
`include "phy_rx_consts.svh"

module tb_phy_rx;
    import phy_rx_status_pkg::*;

    localparam int WORD_W = `PHY_DATA_W + `PHY_HDR_W;
    localparam int SLIP_GAP = 2 * (`BITSLIP_HIGH + `BITSLIP_LOW);
    localparam int WAIT_LIMIT = 4 * `SYNC_WINDOW;
    // flips kept clear of the x^28 echo inside the same word
    localparam logic [WORD_W-1:0] FLIP_MASK = {{(WORD_W-6){1'b1}}, 6'b0};

    logic clk;
    logic rst;
    logic [`PHY_DATA_W-1:0] serdes_rx_data;
    logic serdes_rx_data_valid;
    logic [`PHY_HDR_W-1:0] serdes_rx_hdr;
    logic serdes_rx_hdr_valid;
    logic cfg_rx_prbs31_enable;
    logic [`PHY_DATA_W-1:0] encoded_rx_data;
    logic encoded_rx_data_valid;
    logic [`PHY_HDR_W-1:0] encoded_rx_hdr;
    logic encoded_rx_hdr_valid;
    logic serdes_rx_bitslip;
    logic rx_block_lock;
    err_cnt_t rx_error_count;

    // reference model state
    integer seed;
    int nvalid;
    logic [`SCR_W-1:0] scr_state;
    logic [`PRBS_W-1:0] prbs_state;
    logic prbs_mode;
    logic slip_ok;

    // expectations for the word on the pins
    logic [`PHY_DATA_W-1:0] exp_data;
    logic data_chk;
    err_cnt_t exp_err;
    logic err_chk;

    // the same values lined up with DUT latency
    logic dv_q;
    logic hv_q;
    logic data_chk_q;
    logic [`PHY_HDR_W-1:0] hdr_q;
    logic [`PHY_DATA_W-1:0] data_q;
    logic [2:0][`ERR_CNT_W-1:0] err_pipe;
    logic [2:0] err_chk_pipe;
    logic hdr_seen;
    logic hdr_bad;
    int good_run;
    int bad_locked;
    int since_slip;

    tb_clk_gen clk_gen (.clk(clk), .rst(rst));

    phy_rx_top DUT (.*);

    assign hdr_seen = serdes_rx_data_valid && serdes_rx_hdr_valid;
    // legal headers differ in their two bits
    assign hdr_bad = serdes_rx_hdr[1] == serdes_rx_hdr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            dv_q <= 1'b0;
            hv_q <= 1'b0;
            data_chk_q <= 1'b0;
            hdr_q <= '0;
            data_q <= '0;
            err_pipe <= '0;
            err_chk_pipe <= '0;
            good_run <= 0;
            bad_locked <= 0;
            since_slip <= 1000;
        end else begin
            dv_q <= serdes_rx_data_valid;
            hv_q <= serdes_rx_hdr_valid;
            data_chk_q <= data_chk && serdes_rx_data_valid;
            hdr_q <= serdes_rx_hdr;
            data_q <= exp_data;
            // count lands three edges after its word
            err_pipe <= {err_pipe[1:0], exp_err};
            err_chk_pipe <= {err_chk_pipe[1:0], err_chk};
            // run of good headers seen on the line
            if (hdr_seen) begin
                good_run <= hdr_bad ? 0 : good_run + 1;
            end
            // bad headers while locked
            if (!rx_block_lock) begin
                bad_locked <= 0;
            end else if (hdr_seen && hdr_bad) begin
                bad_locked <= bad_locked + 1;
            end
            // cycles since the last bitslip
            if (serdes_rx_bitslip) begin
                since_slip <= 0;
            end else if (since_slip < 1000) begin
                since_slip <= since_slip + 1;
            end
        end
    end

    a_data: assert property (@(posedge clk) disable iff (rst)
        data_chk_q |-> encoded_rx_data == data_q)
        else flag_mismatch("encoded_rx_data", 64'($sampled(encoded_rx_data)),
            64'($sampled(data_q)));
    a_hdr: assert property (@(posedge clk) disable iff (rst)
        dv_q |-> encoded_rx_hdr == hdr_q)
        else flag_mismatch("encoded_rx_hdr", 64'($sampled(encoded_rx_hdr)),
            64'($sampled(hdr_q)));
    a_dv: assert property (@(posedge clk) disable iff (rst) encoded_rx_data_valid == dv_q)
        else flag_mismatch("encoded_rx_data_valid", 64'($sampled(encoded_rx_data_valid)),
            64'($sampled(dv_q)));
    a_hv: assert property (@(posedge clk) disable iff (rst) encoded_rx_hdr_valid == hv_q)
        else flag_mismatch("encoded_rx_hdr_valid", 64'($sampled(encoded_rx_hdr_valid)),
            64'($sampled(hv_q)));
    a_err: assert property (@(posedge clk) disable iff (rst)
        err_chk_pipe[2] |-> rx_error_count == err_pipe[2])
        else flag_mismatch("rx_error_count", 64'($sampled(rx_error_count)),
            64'($sampled(err_pipe[2])));
    a_lock_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(rx_block_lock) |-> good_run >= `SYNC_WINDOW)
        else stop_run("block lock rose before a full window of good headers");
    a_lock_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(rx_block_lock) |-> bad_locked >= `SYNC_BAD_MAX)
        else stop_run("block lock fell with too few invalid headers");
    a_slip_due: assert property (@(posedge clk) disable iff (rst)
        serdes_rx_bitslip |-> slip_ok)
        else stop_run("bitslip pulsed where no slip was due");
    a_slip_gap: assert property (@(posedge clk) disable iff (rst)
        $rose(serdes_rx_bitslip) |-> since_slip > `BITSLIP_LOW)
        else stop_run("second bitslip came while headers were still ignored");
    a_slip_prbs: assert property (@(posedge clk) disable iff (rst)
        cfg_rx_prbs31_enable |-> !serdes_rx_bitslip)
        else stop_run("bitslip pulsed with PRBS31 checking enabled");

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
        $display("SOME TESTS FAILED");
        $fatal(1, "value check failed");
    endtask

    task automatic stop_run(input string what);
        $display("ERROR: %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // one valid word either scrambled by the x^58 + x^39 + 1 model or sent raw
    task automatic send_word(input logic [`PHY_DATA_W-1:0] payload,
                             input logic [`PHY_HDR_W-1:0] hdr, input logic scramble,
                             input logic count_chk, input int nerr);
        logic [`PHY_DATA_W-1:0] line;
        logic sb;
        @(posedge clk);
        #2;
        for (int i = 0; i < `PHY_DATA_W; i++) begin
            sb = payload[i];
            if (scramble) begin
                sb = sb ^ scr_state[`SCR_W-`SCR_TAP] ^ scr_state[0];
            end
            line[i] = sb;
            // newest line bit at the top
            scr_state = {sb, scr_state[`SCR_W-1:1]};
        end
        serdes_rx_data = line;
        serdes_rx_data_valid = 1'b1;
        serdes_rx_hdr = hdr;
        // a 66b block spans two 32-bit words
        serdes_rx_hdr_valid = nvalid % 2 == 0;
        cfg_rx_prbs31_enable = prbs_mode;
        exp_data = payload;
        data_chk = scramble && nvalid >= 2;
        err_chk = prbs_mode ? count_chk : 1'b1;
        exp_err = prbs_mode ? err_cnt_t'(nerr) : '0;
        nvalid++;
    endtask

    // gearbox gap where nothing may move
    task automatic drive_idle();
        @(posedge clk);
        #2;
        serdes_rx_data = $random(seed);
        serdes_rx_data_valid = 1'b0;
        serdes_rx_hdr_valid = 1'b0;
        cfg_rx_prbs31_enable = prbs_mode;
        data_chk = 1'b0;
        err_chk = 1'b1;
        exp_err = '0;
    endtask

    // random payload with a random legal header
    task automatic send_random(input logic [`PHY_HDR_W-1:0] bad_hdr, input logic use_bad);
        logic [31:0] rnd;
        logic [31:0] pick;
        rnd = $random(seed);
        pick = $random(seed);
        send_word(rnd, use_bad ? bad_hdr : (pick[0] ? 2'b01 : 2'b10), 1'b1, 1'b1, 0);
    endtask

    // next PRBS31 word sent inverted with chosen bits flipped
    task automatic send_prbs(input logic [WORD_W-1:0] flips, input logic count_chk);
        logic [WORD_W-1:0] w;
        logic b;
        int nerr;
        nerr = 0;
        for (int i = 0; i < WORD_W; i++) begin
            b = prbs_state[`PRBS_W-`PRBS_TAP] ^ prbs_state[0];
            w[i] = b;
            prbs_state = {b, prbs_state[`PRBS_W-1:1]};
            nerr += int'(flips[i]);
        end
        w = ~w ^ flips;
        send_word(w[WORD_W-1:`PHY_HDR_W], w[`PHY_HDR_W-1:0], 1'b0, count_chk, nerr);
    endtask

    initial begin
        int n;
        logic [31:0] rnd;
        logic [31:0] rnd_hi;
        seed = 78;
        nvalid = 0;
        scr_state = '1;
        prbs_state = 31'h2aaa_5555;
        prbs_mode = 1'b0;
        slip_ok = 1'b0;
        serdes_rx_data = '0;
        serdes_rx_data_valid = 1'b0;
        serdes_rx_hdr = '0;
        serdes_rx_hdr_valid = 1'b0;
        cfg_rx_prbs31_enable = 1'b0;
        exp_data = '0;
        data_chk = 1'b0;
        exp_err = '0;
        err_chk = 1'b0;
        // first edge comes while reset is surely asserted
        n = 0;
        do begin
            if (n == 10) stop_run("reset was never released");
            @(posedge clk);
            n++;
        end while (rst);

        // invalid headers while hunting give slips spaced by the ignore period
        slip_ok = 1'b1;
        n = 0;
        while (!serdes_rx_bitslip) begin
            if (n == WAIT_LIMIT) stop_run("no bitslip after an invalid header");
            send_random(2'b11, 1'b1);
            n++;
        end
        repeat (SLIP_GAP) send_random(2'b00, 1'b1);
        repeat (SLIP_GAP) send_random(2'b00, 1'b0);
        slip_ok = 1'b0;

        // descrambling with gearbox gaps between words
        repeat (200) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00) drive_idle();
            send_random(2'b00, 1'b0);
        end

        // good headers only until lock
        n = 0;
        while (!rx_block_lock) begin
            if (n == WAIT_LIMIT) stop_run("block lock was not gained");
            send_random(2'b00, 1'b0);
            n++;
        end

        // invalid headers until lock drops and a slip follows
        slip_ok = 1'b1;
        n = 0;
        while (rx_block_lock) begin
            if (n == WAIT_LIMIT) stop_run("block lock did not drop on invalid headers");
            send_random(2'b11, 1'b1);
            n++;
        end
        n = 0;
        while (!serdes_rx_bitslip) begin
            if (n == SLIP_GAP) stop_run("no bitslip after block lock dropped");
            send_random(2'b00, 1'b0);
            n++;
        end
        repeat (SLIP_GAP) send_random(2'b00, 1'b0);
        slip_ok = 1'b0;

        // PRBS31 stream whose headers are random and often invalid
        prbs_mode = 1'b1;
        for (int w = 0; w < 6; w++) begin
            send_prbs('0, w >= 2);
        end
        repeat (8) begin
            rnd = $random(seed);
            rnd_hi = $random(seed);
            send_prbs({rnd_hi[1:0], rnd} & FLIP_MASK, 1'b1);
            // flips echo into the next word
            send_prbs('0, 1'b0);
            drive_idle();
            send_prbs('0, 1'b1);
            send_prbs('0, 1'b1);
        end

        // with the checker off the count must stay zero
        slip_ok = 1'b1;
        prbs_mode = 1'b0;
        repeat (40) send_random(2'b00, 1'b0);
        repeat (4) drive_idle();
        $display("ALL TESTS PASSED");
        $finish;
    end
endmodule

/* flist.f */
+incdir+rtl
rtl/phy_rx_block_pkg.sv
rtl/phy_rx_status_pkg.sv
rtl/serdes_rx_if.sv
rtl/rx_descrambler.sv
rtl/prbs31_checker.sv
rtl/block_sync_ctrl.sv
rtl/phy_rx_top.sv
dv/tb_clk_gen.sv
dv/tb_phy_rx.sv

/* Bender.yml */
package:
  name: phy_rx

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/phy_rx_block_pkg.sv
      - rtl/phy_rx_status_pkg.sv
      - rtl/serdes_rx_if.sv
      - rtl/rx_descrambler.sv
      - rtl/prbs31_checker.sv
      - rtl/block_sync_ctrl.sv
      - rtl/phy_rx_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_phy_rx.sv
